// ==== verilog/tdc_timing_pkg.sv ====
package tdc_timing_pkg;

    localparam int COARSE_W = 11;   // coarse cycle count
    localparam int FINE_W   = 4;    // fine code from the delay line
    localparam int TIME_W   = COARSE_W + FINE_W;
    localparam int PHASE_W  = 16;   // delay-line taps

    // one time word, seen whole or split into coarse and fine fields
    typedef struct packed {
        logic [COARSE_W-1:0] coarse;
        logic [FINE_W-1:0]   fine;
    } tdc_time_fields_t;

    typedef union packed {
        logic [TIME_W-1:0] raw;
        tdc_time_fields_t  f;
    } tdc_time_u;

endpackage

// ==== verilog/tdc_frame_pkg.sv ====
package tdc_frame_pkg;

    localparam int MAX_HITS  = 3;   // hits kept per window
    localparam int HIT_CNT_W = 2;
    localparam int INT_W     = 4;   // intensity field

    localparam logic [14:0] NO_HIT_CODE = 15'h7fff;

    // frame sender states
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_SEND = 1'b1;

endpackage

// ==== verilog/tdc_window_ctrl.sv ====
`timescale 1ns/100ps

module tdc_window_ctrl
    import tdc_timing_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  tdc_time_u range_i,
    input  logic      frame_done_i,
    output logic      busy_o,
    output tdc_time_u range_o,
    output logic      start_fire_o
);

    // start only counts while idle
    assign start_fire_o = start_i & ~busy_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o      <= 1'b0;
            range_o.raw <= '1;      // full range until the first start
        end else if (start_fire_o) begin
            busy_o  <= 1'b1;
            range_o <= range_i;
        end else if (frame_done_i) begin
            busy_o <= 1'b0;
        end
    end

    // frame done only ever ends a running measurement
    a_done_while_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_done_i |-> busy_o
    );

endmodule

// ==== verilog/tdc_coarse_counter.sv ====
`timescale 1ns/100ps

module tdc_coarse_counter
    import tdc_timing_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_fire_i,
    input  tdc_time_u           range_i,
    output logic [COARSE_W-1:0] coarse_cnt_o,
    output logic                window_open_o,
    output logic                window_end_o
);

    logic [COARSE_W-1:0] cnt_nxt;

    assign cnt_nxt = coarse_cnt_o + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coarse_cnt_o  <= '0;
            window_open_o <= 1'b0;
            window_end_o  <= 1'b0;
        end else begin
            window_end_o <= 1'b0;
            if (start_fire_i) begin
                coarse_cnt_o  <= '0;
                window_open_o <= 1'b1;
            end else if (window_open_o) begin
                coarse_cnt_o <= cnt_nxt;
                if (cnt_nxt >= range_i.f.coarse) begin   // range reached
                    window_open_o <= 1'b0;
                    window_end_o  <= 1'b1;
                end
            end
        end
    end

    // the range compared against holds while the window is open
    a_range_held : assert property (
        @(posedge clk) disable iff (!rst_n)
        window_open_o |=> $stable(range_i)
    );

endmodule

// ==== verilog/tdc_hit_capture.sv ====
`timescale 1ns/100ps

module tdc_hit_capture
    import tdc_timing_pkg::*;
    import tdc_frame_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_fire_i,
    input  logic                 hit_i,
    input  logic [PHASE_W-1:0]   phase_i,
    input  logic [15:0]          spad_en_i,
    input  logic                 window_open_i,
    input  logic [COARSE_W-1:0]  coarse_cnt_i,
    output logic [PHASE_W-1:0]   start_phase_o,
    output logic [HIT_CNT_W-1:0] hit_count_o,
    output logic [COARSE_W-1:0]  hit_coarse_o [MAX_HITS],
    output logic [PHASE_W-1:0]   hit_phase_o [MAX_HITS],
    output logic [15:0]          hit_spad_o [MAX_HITS]
);

    logic               hit_q;
    logic               hit_qq;
    logic [PHASE_W-1:0] phase_q;    // phase and spads line up with hit_q
    logic [15:0]        spad_q;
    logic               store_en;

    // rising edge seen one cycle late, so the count in hand is d
    assign store_en = window_open_i & hit_q & ~hit_qq
                    & (hit_count_o < HIT_CNT_W'(MAX_HITS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_q       <= 1'b0;
            hit_qq      <= 1'b0;
            hit_count_o <= '0;
        end else begin
            hit_q  <= hit_i;
            hit_qq <= hit_q;
            if (start_fire_i) begin
                hit_count_o <= '0;
            end else if (store_en) begin
                hit_count_o <= hit_count_o + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // hit store
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        phase_q <= phase_i;
        spad_q  <= spad_en_i;
        if (start_fire_i) begin
            start_phase_o <= phase_i;       // phase at the start edge
        end
        if (store_en) begin
            hit_coarse_o[hit_count_o] <= coarse_cnt_i;
            hit_phase_o[hit_count_o]  <= phase_q;
            hit_spad_o[hit_count_o]   <= spad_q;
        end
    end

    // stored coarse counts rise from slot to slot
    a_coarse_ordered : assert property (
        @(posedge clk) disable iff (!rst_n)
        store_en && (hit_count_o != '0)
            |-> coarse_cnt_i > hit_coarse_o[hit_count_o - 1'b1]
    );

endmodule

// ==== verilog/tdc_hit_calc.sv ====
`timescale 1ns/100ps

module tdc_hit_calc
    import tdc_timing_pkg::*;
    import tdc_frame_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 window_end_i,
    input  logic [HIT_CNT_W-1:0] hit_count_i,
    input  logic [PHASE_W-1:0]   start_phase_i,
    input  logic [COARSE_W-1:0]  hit_coarse_i [MAX_HITS],
    input  logic [PHASE_W-1:0]   hit_phase_i [MAX_HITS],
    input  logic [15:0]          hit_spad_i [MAX_HITS],
    output logic                 calc_done_o,
    output tdc_time_u            tof_o [MAX_HITS],
    output logic [INT_W-1:0]     int_o [MAX_HITS]
);

    // set bits of a 16-bit word, capped to fit in four bits
    function automatic logic [FINE_W-1:0] ones_capped(input logic [PHASE_W-1:0] w);
        logic [4:0] n;
        n = '0;
        for (int i = 0; i < PHASE_W; i++) begin
            n = n + 5'(w[i]);
        end
        return (n > 5'd15) ? 4'hf : n[3:0];
    endfunction

    logic                 issuing;
    logic [HIT_CNT_W-1:0] issue_idx;
    logic [HIT_CNT_W-1:0] issue_nxt;
    logic                 s1_valid;
    logic                 s1_last;
    logic                 s1_write;   // low for the empty-window token
    logic                 s2_done;
    logic [HIT_CNT_W-1:0] s1_idx;
    logic [COARSE_W-1:0]  s1_coarse;
    logic [FINE_W-1:0]    s1_hit_fine;
    logic [FINE_W-1:0]    s1_start_fine;
    logic [INT_W-1:0]     s1_int;
    tdc_time_u            hit_time;
    tdc_time_u            tof_word;

    assign issue_nxt = issue_idx + 1'b1;

    // ------------------------------------------------------------------------
    // issue and pipeline control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issuing     <= 1'b0;
            issue_idx   <= '0;
            s1_valid    <= 1'b0;
            s1_last     <= 1'b0;
            s1_write    <= 1'b0;
            s2_done     <= 1'b0;
            calc_done_o <= 1'b0;
        end else begin
            s1_valid    <= 1'b0;
            s2_done     <= s1_valid & s1_last;
            calc_done_o <= s2_done;
            if (window_end_i && hit_count_i == '0) begin
                s1_valid <= 1'b1;   // nothing to compute so only time the done
                s1_last  <= 1'b1;
                s1_write <= 1'b0;
            end else if (window_end_i) begin
                issuing   <= 1'b1;
                issue_idx <= '0;
            end else if (issuing) begin
                s1_valid <= 1'b1;
                s1_write <= 1'b1;
                s1_last  <= (issue_nxt == hit_count_i);
                if (issue_nxt == hit_count_i) begin
                    issuing <= 1'b0;
                end
                issue_idx <= issue_nxt;
            end
        end
    end

    // stage 1 decodes the fine codes and the spad count
    always_ff @(posedge clk) begin
        if (issuing) begin
            s1_idx        <= issue_idx;
            s1_coarse     <= hit_coarse_i[issue_idx];
            s1_hit_fine   <= ones_capped(hit_phase_i[issue_idx]);
            s1_start_fine <= ones_capped(start_phase_i);
            s1_int        <= ones_capped(hit_spad_i[issue_idx]);
        end
    end

    // stage 2 builds coarse*16 + fine and takes off the start fine
    always_comb begin
        hit_time.f.coarse = s1_coarse;
        hit_time.f.fine   = s1_hit_fine;
        tof_word.raw      = hit_time.raw - TIME_W'(s1_start_fine);   // wraps mod 2^15
    end

    always_ff @(posedge clk) begin
        if (s1_valid && s1_write) begin
            tof_o[s1_idx] <= tof_word;
            int_o[s1_idx] <= s1_int;
        end
    end

endmodule

// ==== verilog/tdc_frame_tx.sv ====
`timescale 1ns/100ps

module tdc_frame_tx
    import tdc_timing_pkg::*;
    import tdc_frame_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 calc_done_i,
    input  logic [HIT_CNT_W-1:0] hit_count_i,
    input  logic [TIME_W-1:0]    tof_i [MAX_HITS],
    input  logic [INT_W-1:0]     int_i [MAX_HITS],
    input  logic                 ready_i,
    output logic [TIME_W-1:0]    data_o,
    output logic [INT_W-1:0]     int_o,
    output logic [HIT_CNT_W-1:0] num_o,
    output logic                 last_o,
    output logic                 valid_o,
    output logic                 frame_done_o
);

    logic                 state_q;
    logic [HIT_CNT_W-1:0] idx_q;
    logic [HIT_CNT_W-1:0] idx_nxt;
    logic                 load_first;
    logic                 advance;    // transfer of a word that is not the last

    assign valid_o    = (state_q == ST_SEND);
    assign idx_nxt    = idx_q + 1'b1;
    assign load_first = (state_q == ST_IDLE) & calc_done_i;
    assign advance    = valid_o & ready_i & ~last_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            idx_q        <= '0;
            last_o       <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            frame_done_o <= 1'b0;
            if (load_first) begin
                state_q <= ST_SEND;
                idx_q   <= '0;
                last_o  <= (hit_count_i <= HIT_CNT_W'(1));  // no-hit word is last too
            end else if (valid_o && ready_i && last_o) begin
                state_q      <= ST_IDLE;
                last_o       <= 1'b0;
                frame_done_o <= 1'b1;
            end else if (advance) begin
                idx_q  <= idx_nxt;
                last_o <= (idx_nxt + 1'b1 == hit_count_i);
            end
        end
    end

    // ------------------------------------------------------------------------
    // word payload
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load_first) begin
            num_o <= hit_count_i;
            if (hit_count_i == '0) begin
                data_o <= NO_HIT_CODE;
                int_o  <= '0;
            end else begin
                data_o <= tof_i[0];
                int_o  <= int_i[0];
            end
        end else if (advance) begin
            data_o <= tof_i[idx_nxt];
            int_o  <= int_i[idx_nxt];
        end
    end

    // hit count stays put while its frame goes out
    a_count_held : assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o |-> $stable(hit_count_i)
    );

endmodule

// ==== verilog/tdc_top.sv ====
`timescale 1ns/100ps

module tdc_top
    import tdc_timing_pkg::*;
    import tdc_frame_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  tdc_time_u            range_i,
    input  logic                 hit_i,
    input  logic [PHASE_W-1:0]   phase_i,
    input  logic [15:0]          spad_en_i,
    output logic [TIME_W-1:0]    data_o,
    output logic [INT_W-1:0]     int_o,
    output logic [HIT_CNT_W-1:0] num_o,
    output logic                 last_o,
    output logic                 valid_o,
    input  logic                 ready_i,
    output logic                 busy_o
);

    tdc_time_u            range_q;
    logic                 start_fire;
    logic [COARSE_W-1:0]  coarse_cnt;
    logic                 window_open;
    logic                 window_end;
    logic [PHASE_W-1:0]   start_phase;
    logic [HIT_CNT_W-1:0] hit_count;
    logic [COARSE_W-1:0]  hit_coarse [MAX_HITS];
    logic [PHASE_W-1:0]   hit_phase [MAX_HITS];
    logic [15:0]          hit_spad [MAX_HITS];
    logic                 calc_done;
    tdc_time_u            tof [MAX_HITS];
    logic [INT_W-1:0]     int_res [MAX_HITS];
    logic                 frame_done;

    tdc_window_ctrl u_window_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .range_i      (range_i),
        .frame_done_i (frame_done),
        .busy_o       (busy_o),
        .range_o      (range_q),
        .start_fire_o (start_fire)
    );

    tdc_coarse_counter u_coarse_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_fire_i  (start_fire),
        .range_i       (range_q),
        .coarse_cnt_o  (coarse_cnt),
        .window_open_o (window_open),
        .window_end_o  (window_end)
    );

    tdc_hit_capture u_hit_capture (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_fire_i  (start_fire),
        .hit_i         (hit_i),
        .phase_i       (phase_i),
        .spad_en_i     (spad_en_i),
        .window_open_i (window_open),
        .coarse_cnt_i  (coarse_cnt),
        .start_phase_o (start_phase),
        .hit_count_o   (hit_count),
        .hit_coarse_o  (hit_coarse),
        .hit_phase_o   (hit_phase),
        .hit_spad_o    (hit_spad)
    );

    tdc_hit_calc u_hit_calc (
        .clk           (clk),
        .rst_n         (rst_n),
        .window_end_i  (window_end),
        .hit_count_i   (hit_count),
        .start_phase_i (start_phase),
        .hit_coarse_i  (hit_coarse),
        .hit_phase_i   (hit_phase),
        .hit_spad_i    (hit_spad),
        .calc_done_o   (calc_done),
        .tof_o         (tof),
        .int_o         (int_res)
    );

    tdc_frame_tx u_frame_tx (
        .clk          (clk),
        .rst_n        (rst_n),
        .calc_done_i  (calc_done),
        .hit_count_i  (hit_count),
        .tof_i        (tof),
        .int_i        (int_res),
        .ready_i      (ready_i),
        .data_o       (data_o),
        .int_o        (int_o),
        .num_o        (num_o),
        .last_o       (last_o),
        .valid_o      (valid_o),
        .frame_done_o (frame_done)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD = 5;     // half of the 10 ns period

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset held for ten cycles and released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== verification/tb_tdc.sv ====
`timescale 1ns/100ps

module tb_tdc
    import tdc_timing_pkg::*;
    import tdc_frame_pkg::*;
();

    localparam int WAIT_LIMIT = 200;    // cycles allowed per wait

    logic                 clk;
    logic                 rst_n;
    logic                 start_i;
    tdc_time_u            range_i;
    logic                 hit_i;
    logic [PHASE_W-1:0]   phase_i;
    logic [15:0]          spad_en_i;
    logic                 ready_i;
    logic [TIME_W-1:0]    data_o;
    logic [INT_W-1:0]     int_o;
    logic [HIT_CNT_W-1:0] num_o;
    logic                 last_o;
    logic                 valid_o;
    logic                 busy_o;

    // current vector
    string       test_name;
    logic [14:0] range_word;
    logic [15:0] start_phase;
    int          hit_total;
    int          hit_d [4];
    logic [15:0] hit_phase [4];
    logic [15:0] hit_spad [4];

    // expected frame from the reference model
    int          exp_count;
    logic [14:0] exp_tof [MAX_HITS];
    logic [3:0]  exp_int [MAX_HITS];

    logic [31:0] lcg_state;
    int          tests_run;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    tdc_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .range_i   (range_i),
        .hit_i     (hit_i),
        .phase_i   (phase_i),
        .spad_en_i (spad_en_i),
        .data_o    (data_o),
        .int_o     (int_o),
        .num_o     (num_o),
        .last_o    (last_o),
        .valid_o   (valid_o),
        .ready_i   (ready_i),
        .busy_o    (busy_o)
    );

    // ------------------------------------------------------------------------
    // error handling and compare
    // ------------------------------------------------------------------------
    task automatic abort_run;
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in test %s: %s", test_name, msg);
        abort_run();
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH test=%s %s expected=%0h actual=%0h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic drive_ready;
        lcg_state = lcg_next(lcg_state);
        ready_i   = (lcg_state[17:16] != 2'b00);   // about one stall in four
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic int capped_ones(input logic [15:0] w);
        int n;
        n = $countones(w);
        return (n > 15) ? 15 : n;
    endfunction

    task automatic build_expected;
        int tof;
        exp_count = 0;
        for (int k = 0; k < hit_total && k < 4; k++) begin
            // only hits inside the window, and only the first three
            if (hit_d[k] < int'(range_word[14:4]) && exp_count < MAX_HITS) begin
                tof = hit_d[k] * 16 + capped_ones(hit_phase[k]) - capped_ones(start_phase);
                exp_tof[exp_count] = tof[14:0];     // mod 2^15
                exp_int[exp_count] = 4'(capped_ones(hit_spad[k]));
                exp_count++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus and waits
    // ------------------------------------------------------------------------
    task automatic drive_window;
        int r_coarse;
        r_coarse    = int'(range_word[14:4]);
        start_i     = 1'b1;
        range_i.raw = range_word;
        phase_i     = start_phase;
        @(negedge clk);
        check_value("busy after start", 1, 32'(busy_o));
        for (int c = 1; c <= r_coarse + 2; c++) begin
            start_i     = (c == 2);     // second start, DUT must ignore it
            range_i.raw = ~range_word;
            hit_i       = 1'b0;
            phase_i     = '0;
            spad_en_i   = '0;
            for (int k = 0; k < hit_total && k < 4; k++) begin
                if (hit_d[k] == c) begin
                    hit_i     = 1'b1;
                    phase_i   = hit_phase[k];
                    spad_en_i = hit_spad[k];
                end
            end
            @(negedge clk);
            check_value("busy in window", 1, 32'(busy_o));
        end
        start_i   = 1'b0;
        hit_i     = 1'b0;
        phase_i   = '0;
        spad_en_i = '0;
    endtask

    task automatic wait_valid;
        int waited;
        waited = 0;
        while (!valid_o) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) report_error("timed out waiting for valid_o to rise");
        end
    endtask

    task automatic wait_busy_low;
        int waited;
        waited = 0;
        while (busy_o !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) report_error("timed out waiting for busy_o to fall");
        end
    endtask

    task automatic receive_frame;
        int n_words;
        int waited;
        n_words = (exp_count == 0) ? 1 : exp_count;
        for (int w = 0; w < n_words; w++) begin
            waited = 0;
            drive_ready();
            while (!(valid_o && ready_i)) begin
                @(negedge clk);
                waited++;
                if (waited > WAIT_LIMIT) report_error("timed out waiting for a word transfer");
                drive_ready();
            end
            // word is taken on the coming rising edge
            if (exp_count == 0) begin
                check_value("data", 32'(NO_HIT_CODE), 32'(data_o));
                check_value("intensity", 0, 32'(int_o));
            end else begin
                check_value("data", 32'(exp_tof[w]), 32'(data_o));
                check_value("intensity", 32'(exp_int[w]), 32'(int_o));
            end
            check_value("num", 32'(exp_count), 32'(num_o));
            check_value("last", 32'(w == n_words - 1), 32'(last_o));
            @(negedge clk);
        end
        ready_i = 1'b0;
        check_value("valid after last word", 0, 32'(valid_o));
        check_value("busy after last word", 1, 32'(busy_o));
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int    fd;
        int    fields;
        int    waited;
        string line;
        start_i     = 1'b0;
        range_i.raw = '0;
        hit_i       = 1'b0;
        phase_i     = '0;
        spad_en_i   = '0;
        ready_i     = 1'b0;
        lcg_state   = 32'd32144;
        tests_run   = 0;
        test_name   = "setup";
        fd = $fopen("verification/tdc_vectors.txt", "r");
        if (fd == 0) report_error("cannot open verification/tdc_vectors.txt");
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) report_error("reset was never released");
        end
        @(negedge clk);
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;   // comment or blank
            fields = $sscanf(line, "%s %h %h %d %d %h %h %d %h %h %d %h %h %d %h %h",
                             test_name, range_word, start_phase, hit_total,
                             hit_d[0], hit_phase[0], hit_spad[0],
                             hit_d[1], hit_phase[1], hit_spad[1],
                             hit_d[2], hit_phase[2], hit_spad[2],
                             hit_d[3], hit_phase[3], hit_spad[3]);
            if (fields != 16) report_error("malformed line in the vector file");
            build_expected();
            wait_busy_low();
            drive_window();
            wait_valid();
            receive_frame();
            wait_busy_low();
            tests_run++;
            $display("%s: %0d hit(s) reported", test_name, exp_count);
        end
        $fclose(fd);
        if (tests_run > 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            test_name = "end";
            report_error("no vectors were read from the vector file");
        end
    end

endmodule

// ==== verification/tdc_vectors.txt ====
# name range start_phase hits, then four hit slots of delay phase spad
# range, phase and spad in hex; delay in cycles after start; hit slots in time order
one_hit      0200 0007 1   5 00ff a5c3    0 0000 0000    0 0000 0000    0 0000 0000
two_hits     0300 000f 2   3 0003 ffff   20 7fff 0001    0 0000 0000    0 0000 0000
three_hits   0405 0001 3   1 ffff 0f0f   10 001f 8000   40 03ff ffff    0 0000 0000
no_hits      0157 00ff 0   0 0000 0000    0 0000 0000    0 0000 0000    0 0000 0000
four_hits    0280 0000 4   2 0001 0001    6 0003 0003   11 0007 0007   17 000f 000f
late_hit     0a00 7fff 1 150 fffe 1234    0 0000 0000    0 0000 0000    0 0000 0000
capped_fine  0100 ffff 2   4 ffff ffff    9 0000 0000    0 0000 0000    0 0000 0000
short_empty  0040 0000 0   0 0000 0000    0 0000 0000    0 0000 0000    0 0000 0000
close_hits   0080 3c3c 3   1 1111 2222    3 3333 4444    5 5555 6666    0 0000 0000
four_spread  0600 0aaa 4   7 0fff f0f0   30 00ff 0ff0   60 0f0f ffff   90 ffff 0001

// ==== list.f ====
verilog/tdc_timing_pkg.sv
verilog/tdc_frame_pkg.sv
verilog/tdc_window_ctrl.sv
verilog/tdc_coarse_counter.sv
verilog/tdc_hit_capture.sv
verilog/tdc_hit_calc.sv
verilog/tdc_frame_tx.sv
verilog/tdc_top.sv
verification/tb_clock_gen.sv
verification/tb_tdc.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_tdc -f list.f -o tb_tdc \
    && ./obj_dir/tb_tdc > sim.log 2>&1 \
    || echo "build or simulation error" >> sim.log
cat sim.log
grep -q "Simulation finished: PASS" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
